/* include/riscv_config.svh */
`ifndef RISCV_CONFIG_SVH
`define RISCV_CONFIG_SVH

// Datapath and address width
`define RV_XLEN 32

// Architectural register count
`define RV_NREGS 32

// Register index width
`define RV_REGW 5

// First fetch address out of reset
`define RV_RESET_PC 32'h0000_0000

// Byte step between sequential instructions
`define RV_PC_STEP 32'd4

`endif

/* hw/riscv_isa_pkg.sv */
package riscv_isa_pkg;

   // Major opcodes of the supported RV32I subset
   typedef enum logic [6:0] {
      OP     = 7'b0110011,   // ADD SUB AND OR
      OP_IMM = 7'b0010011,   // ADDI
      LOAD   = 7'b0000011,   // LW
      STORE  = 7'b0100011,   // SW
      BRANCH = 7'b1100011    // BEQ
   } opcode_e;

   // Operations carried out by the execute ALU
   typedef enum logic [1:0] {
      ADD = 2'd0,
      SUB = 2'd1,
      AND = 2'd2,
      OR  = 2'd3
   } alu_op_e;

   localparam logic [2:0] funct3_add  = 3'b000;   // ADD SUB ADDI
   localparam logic [2:0] funct3_and  = 3'b111;
   localparam logic [2:0] funct3_or   = 3'b110;
   localparam logic [2:0] funct3_beq  = 3'b000;
   localparam logic [2:0] funct3_word = 3'b010;   // LW SW

   localparam logic [6:0] funct7_sub  = 7'b0100000;   // Selects SUB over ADD

endpackage

/* hw/riscv_pipe_pkg.sv */
`include "riscv_config.svh"

package riscv_pipe_pkg;

   // Control bundle produced by decode
   typedef struct packed {
      logic regwrite;
      logic memread;
      logic memwrite;
      logic memtoreg;
      logic alusrc;   // Immediate as second operand
      logic branch;
   } ctrl_t;

   typedef struct packed {
      logic                valid;
      logic [`RV_XLEN-1:0] pc;
      logic [31:0]         instr;
   } if_id_t;

   typedef struct packed {
      logic                   valid;
      ctrl_t                  ctrl;
      riscv_isa_pkg::alu_op_e alu_op;
      logic [`RV_XLEN-1:0]    pc;
      logic [`RV_REGW-1:0]    rs1;
      logic [`RV_REGW-1:0]    rs2;
      logic [`RV_REGW-1:0]    rd;
      logic [`RV_XLEN-1:0]    rs1_data;
      logic [`RV_XLEN-1:0]    rs2_data;
      logic [`RV_XLEN-1:0]    imm;
   } id_ex_t;

   typedef struct packed {
      logic                valid;
      logic                regwrite;
      logic                memread;
      logic                memwrite;
      logic                memtoreg;
      logic [`RV_REGW-1:0] rd;
      logic [`RV_XLEN-1:0] result;       // ALU result or data address
      logic [`RV_XLEN-1:0] store_data;
   } ex_mem_t;

   typedef struct packed {
      logic                regwrite;     // Already qualified by valid
      logic [`RV_REGW-1:0] rd;
      logic [`RV_XLEN-1:0] result;
   } mem_wb_t;

   typedef struct packed {
      logic                ce;
      logic [`RV_XLEN-1:0] addr;
   } imem_req_t;

   typedef struct packed {
      logic                ce;
      logic                we;
      logic [`RV_XLEN-1:0] addr;
      logic [`RV_XLEN-1:0] wdata;
   } dmem_req_t;

   typedef struct packed {
      logic                we;
      logic [`RV_REGW-1:0] addr;
      logic [`RV_XLEN-1:0] data;
   } rf_wr_t;

endpackage

/* hw/riscv_fetch.sv */
`include "riscv_config.svh"

module riscv_fetch (
   input  logic                      clk,
   input  logic                      rst_n_i,
   input  logic                      stall_i,
   input  logic                      redirect_i,
   input  logic [`RV_XLEN-1:0]       target_i,
   input  logic [31:0]               inst_i,
   output riscv_pipe_pkg::imem_req_t inst_req_o,
   output riscv_pipe_pkg::if_id_t    if_id_o
);

   logic                   ce_q;   // Fetch enabled one cycle after reset
   logic [`RV_XLEN-1:0]    pc_q;
   riscv_pipe_pkg::if_id_t if_id_q;

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ce_q <= 1'b0;
         pc_q <= `RV_RESET_PC;
      end else begin
         ce_q <= 1'b1;
         if (redirect_i) begin
            pc_q <= target_i;   // Taken branch wins over stall
         end else if (ce_q && !stall_i) begin
            pc_q <= pc_q + `RV_PC_STEP;
         end
      end
   end

   // IF/ID register holds during a load-use stall
   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         if_id_q <= '0;
      end else if (redirect_i) begin
         if_id_q.valid <= 1'b0;   // Squash the wrong-path fetch
      end else if (!stall_i) begin
         if_id_q <= '{valid: ce_q, pc: pc_q, instr: inst_i};
      end
   end

   assign inst_req_o = '{ce: ce_q, addr: pc_q};
   assign if_id_o    = if_id_q;

endmodule

/* hw/riscv_regfile.sv */
`include "riscv_config.svh"

module riscv_regfile (
   input  logic                   clk,
   input  logic                   rst_n_i,
   input  logic [`RV_REGW-1:0]    rs1_i,
   input  logic [`RV_REGW-1:0]    rs2_i,
   input  riscv_pipe_pkg::rf_wr_t rf_wr_i,
   output logic [`RV_XLEN-1:0]    rs1_data_o,
   output logic [`RV_XLEN-1:0]    rs2_data_o
);

   logic [`RV_XLEN-1:0] regs [1:`RV_NREGS-1];   // No storage for x0

   // Write-first read with x0 tied to zero
   function automatic logic [`RV_XLEN-1:0] read_port(input logic [`RV_REGW-1:0] addr);
      if (addr == '0)
         return '0;
      else if (rf_wr_i.we && rf_wr_i.addr == addr)
         return rf_wr_i.data;   // Same-cycle bypass
      else
         return regs[addr];
   endfunction

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         for (int i = 1; i < `RV_NREGS; i++) regs[i] <= '0;
      end else if (rf_wr_i.we && rf_wr_i.addr != '0) begin
         regs[rf_wr_i.addr] <= rf_wr_i.data;
      end
   end

   always_comb begin
      rs1_data_o = read_port(rs1_i);
      rs2_data_o = read_port(rs2_i);
   end

endmodule

/* hw/riscv_decode.sv */
`include "riscv_config.svh"

module riscv_decode (
   input  logic                   clk,
   input  logic                   rst_n_i,
   input  riscv_pipe_pkg::if_id_t if_id_i,
   input  logic [`RV_XLEN-1:0]    rs1_data_i,
   input  logic [`RV_XLEN-1:0]    rs2_data_i,
   input  logic                   redirect_i,
   input  logic                   ex_memread_i,
   input  logic [`RV_REGW-1:0]    ex_rd_i,
   output logic [`RV_REGW-1:0]    rs1_o,
   output logic [`RV_REGW-1:0]    rs2_o,
   output logic                   stall_o,
   output riscv_pipe_pkg::id_ex_t id_ex_o
);

   logic [31:0]            instr;
   riscv_isa_pkg::opcode_e opcode;
   logic [2:0]             funct3;
   logic [6:0]             funct7;
   logic [`RV_XLEN-1:0]    imm_i;
   logic [`RV_XLEN-1:0]    imm_s;
   logic [`RV_XLEN-1:0]    imm_b;
   riscv_pipe_pkg::ctrl_t  ctrl;
   riscv_isa_pkg::alu_op_e alu_op;
   logic [`RV_XLEN-1:0]    imm;
   logic                   uses_rs2;   // Keeps I-type immediates out of hazard checks
   riscv_pipe_pkg::id_ex_t id_ex_q;

   assign instr  = if_id_i.instr;
   assign opcode = riscv_isa_pkg::opcode_e'(instr[6:0]);
   assign funct3 = instr[14:12];
   assign funct7 = instr[31:25];
   assign rs1_o  = instr[19:15];
   assign rs2_o  = instr[24:20];

   assign imm_i = {{(`RV_XLEN-12){instr[31]}}, instr[31:20]};
   assign imm_s = {{(`RV_XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
   assign imm_b = {{(`RV_XLEN-13){instr[31]}}, instr[31], instr[7],
                   instr[30:25], instr[11:8], 1'b0};

   always_comb begin
      ctrl     = '0;   // Unknown opcodes do nothing
      alu_op   = riscv_isa_pkg::ADD;
      imm      = imm_i;
      uses_rs2 = 1'b0;
      case (opcode)
         riscv_isa_pkg::OP: begin
            uses_rs2      = 1'b1;
            ctrl.regwrite = 1'b1;
            case (funct3)
               riscv_isa_pkg::funct3_add:
                  alu_op = (funct7 == riscv_isa_pkg::funct7_sub) ? riscv_isa_pkg::SUB
                                                                 : riscv_isa_pkg::ADD;
               riscv_isa_pkg::funct3_and: alu_op = riscv_isa_pkg::AND;
               riscv_isa_pkg::funct3_or:  alu_op = riscv_isa_pkg::OR;
               default:                   ctrl   = '0;
            endcase
         end
         riscv_isa_pkg::OP_IMM: begin
            if (funct3 == riscv_isa_pkg::funct3_add) begin
               ctrl.regwrite = 1'b1;
               ctrl.alusrc   = 1'b1;
            end
         end
         riscv_isa_pkg::LOAD: begin
            if (funct3 == riscv_isa_pkg::funct3_word) begin
               ctrl.regwrite = 1'b1;
               ctrl.memread  = 1'b1;
               ctrl.memtoreg = 1'b1;
               ctrl.alusrc   = 1'b1;
            end
         end
         riscv_isa_pkg::STORE: begin
            uses_rs2 = 1'b1;
            imm      = imm_s;
            if (funct3 == riscv_isa_pkg::funct3_word) begin
               ctrl.memwrite = 1'b1;
               ctrl.alusrc   = 1'b1;
            end
         end
         riscv_isa_pkg::BRANCH: begin
            uses_rs2 = 1'b1;
            imm      = imm_b;
            alu_op   = riscv_isa_pkg::SUB;
            if (funct3 == riscv_isa_pkg::funct3_beq) ctrl.branch = 1'b1;
         end
         default: ;
      endcase
   end

   // Load in execute feeding an operand of this instruction
   assign stall_o = if_id_i.valid && ex_memread_i && ex_rd_i != '0 &&
                    (rs1_o == ex_rd_i || (uses_rs2 && rs2_o == ex_rd_i));

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         id_ex_q <= '0;
      end else begin
         id_ex_q <= '{valid:    if_id_i.valid && !stall_o && !redirect_i,   // Bubble
                      ctrl:     ctrl,
                      alu_op:   alu_op,
                      pc:       if_id_i.pc,
                      rs1:      rs1_o,
                      rs2:      rs2_o,
                      rd:       instr[11:7],
                      rs1_data: rs1_data_i,
                      rs2_data: rs2_data_i,
                      imm:      imm};
      end
   end

   assign id_ex_o = id_ex_q;

endmodule

/* hw/riscv_execute.sv */
`include "riscv_config.svh"

module riscv_execute (
   input  logic                    clk,
   input  logic                    rst_n_i,
   input  riscv_pipe_pkg::id_ex_t  id_ex_i,
   input  riscv_pipe_pkg::mem_wb_t mem_wb_i,
   output logic                    ex_memread_o,
   output logic [`RV_REGW-1:0]     ex_rd_o,
   output logic                    redirect_o,
   output logic [`RV_XLEN-1:0]     target_o,
   output riscv_pipe_pkg::ex_mem_t ex_mem_o
);

   logic [`RV_XLEN-1:0]     op_a;
   logic [`RV_XLEN-1:0]     rs2_val;
   logic [`RV_XLEN-1:0]     op_b;
   logic [`RV_XLEN-1:0]     alu_res;
   riscv_pipe_pkg::ex_mem_t ex_mem_q;

   // Newest producer first; loads in EX/MEM are covered by the stall
   function automatic logic [`RV_XLEN-1:0] fwd(input logic [`RV_REGW-1:0]    rs,
                                               input logic [`RV_XLEN-1:0]    data,
                                               input riscv_pipe_pkg::ex_mem_t em,
                                               input riscv_pipe_pkg::mem_wb_t mw);
      if (rs != '0 && em.valid && em.regwrite && !em.memread && em.rd == rs)
         return em.result;
      else if (rs != '0 && mw.regwrite && mw.rd == rs)
         return mw.result;
      else
         return data;
   endfunction

   assign op_a    = fwd(id_ex_i.rs1, id_ex_i.rs1_data, ex_mem_q, mem_wb_i);
   assign rs2_val = fwd(id_ex_i.rs2, id_ex_i.rs2_data, ex_mem_q, mem_wb_i);
   assign op_b    = id_ex_i.ctrl.alusrc ? id_ex_i.imm : rs2_val;

   always_comb begin
      case (id_ex_i.alu_op)
         riscv_isa_pkg::ADD: alu_res = op_a + op_b;
         riscv_isa_pkg::SUB: alu_res = op_a - op_b;   // Wraps at XLEN
         riscv_isa_pkg::AND: alu_res = op_a & op_b;
         riscv_isa_pkg::OR:  alu_res = op_a | op_b;
         default:            alu_res = op_a + op_b;
      endcase
   end

   // BEQ resolves here and squashes the two younger stages
   assign redirect_o = id_ex_i.valid && id_ex_i.ctrl.branch && (op_a == rs2_val);
   assign target_o   = id_ex_i.pc + id_ex_i.imm;

   assign ex_memread_o = id_ex_i.valid && id_ex_i.ctrl.memread;   // For load-use check
   assign ex_rd_o      = id_ex_i.rd;

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ex_mem_q <= '0;
      end else begin
         ex_mem_q <= '{valid:      id_ex_i.valid,
                       regwrite:   id_ex_i.ctrl.regwrite,
                       memread:    id_ex_i.ctrl.memread,
                       memwrite:   id_ex_i.ctrl.memwrite,
                       memtoreg:   id_ex_i.ctrl.memtoreg,
                       rd:         id_ex_i.rd,
                       result:     alu_res,
                       store_data: rs2_val};
      end
   end

   assign ex_mem_o = ex_mem_q;

endmodule

/* hw/riscv_memory.sv */
`include "riscv_config.svh"

module riscv_memory (
   input  logic                      clk,
   input  logic                      rst_n_i,
   input  riscv_pipe_pkg::ex_mem_t   ex_mem_i,
   input  logic [`RV_XLEN-1:0]       data_i,
   output riscv_pipe_pkg::dmem_req_t data_req_o,
   output riscv_pipe_pkg::mem_wb_t   mem_wb_o,
   output riscv_pipe_pkg::rf_wr_t    rf_wr_o
);

   logic                    access;
   riscv_pipe_pkg::mem_wb_t mem_wb_q;

   assign access = ex_mem_i.valid && (ex_mem_i.memread || ex_mem_i.memwrite);

   // Data port answers reads in the same cycle
   assign data_req_o = '{ce:    access,
                         we:    ex_mem_i.valid && ex_mem_i.memwrite,
                         addr:  ex_mem_i.result,
                         wdata: ex_mem_i.store_data};

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         mem_wb_q <= '0;
      end else begin
         mem_wb_q <= '{regwrite: ex_mem_i.valid && ex_mem_i.regwrite,
                       rd:       ex_mem_i.rd,
                       result:   ex_mem_i.memtoreg ? data_i : ex_mem_i.result};
      end
   end

   assign mem_wb_o = mem_wb_q;   // Also forwarded into execute

   // Written at the end of the writeback cycle
   assign rf_wr_o = '{we:   mem_wb_q.regwrite,
                      addr: mem_wb_q.rd,
                      data: mem_wb_q.result};

endmodule

/* hw/riscv.sv */
`include "riscv_config.svh"

module riscv (
   input  logic                      clk,
   input  logic                      rst_n_i,
   output riscv_pipe_pkg::imem_req_t inst_req_o,
   input  logic [31:0]               inst_i,
   output riscv_pipe_pkg::dmem_req_t data_req_o,
   input  logic [`RV_XLEN-1:0]       data_i
);

   riscv_pipe_pkg::if_id_t  if_id;
   riscv_pipe_pkg::id_ex_t  id_ex;
   riscv_pipe_pkg::ex_mem_t ex_mem;
   riscv_pipe_pkg::mem_wb_t mem_wb;
   riscv_pipe_pkg::rf_wr_t  rf_wr;
   logic [`RV_REGW-1:0]     rs1;
   logic [`RV_REGW-1:0]     rs2;
   logic [`RV_REGW-1:0]     ex_rd;
   logic [`RV_XLEN-1:0]     rs1_data;
   logic [`RV_XLEN-1:0]     rs2_data;
   logic [`RV_XLEN-1:0]     target;
   logic                    stall;      // Load-use hold
   logic                    redirect;   // Taken BEQ flush
   logic                    ex_memread;

   riscv_fetch fetch_i (
      .clk, .rst_n_i, .stall_i(stall), .redirect_i(redirect), .target_i(target),
      .inst_i, .inst_req_o, .if_id_o(if_id)
   );

   riscv_regfile regfile_i (
      .clk, .rst_n_i, .rs1_i(rs1), .rs2_i(rs2), .rf_wr_i(rf_wr),
      .rs1_data_o(rs1_data), .rs2_data_o(rs2_data)
   );

   riscv_decode decode_i (
      .clk, .rst_n_i, .if_id_i(if_id), .rs1_data_i(rs1_data), .rs2_data_i(rs2_data),
      .redirect_i(redirect), .ex_memread_i(ex_memread), .ex_rd_i(ex_rd),
      .rs1_o(rs1), .rs2_o(rs2), .stall_o(stall), .id_ex_o(id_ex)
   );

   riscv_execute execute_i (
      .clk, .rst_n_i, .id_ex_i(id_ex), .mem_wb_i(mem_wb),
      .ex_memread_o(ex_memread), .ex_rd_o(ex_rd), .redirect_o(redirect),
      .target_o(target), .ex_mem_o(ex_mem)
   );

   riscv_memory memory_i (
      .clk, .rst_n_i, .ex_mem_i(ex_mem), .data_i,
      .data_req_o, .mem_wb_o(mem_wb), .rf_wr_o(rf_wr)
   );

endmodule

/* test/riscv_props.sv */
module riscv_props (
   input logic                      clk,
   input logic                      rst_n_i,
   input riscv_pipe_pkg::imem_req_t inst_req_i,
   input riscv_pipe_pkg::dmem_req_t data_req_i,
   input logic                      stall_i
);
   timeunit 1ns;
   timeprecision 1ps;

   we_needs_ce: assert property (@(posedge clk) disable iff (!rst_n_i)
                                 data_req_i.we |-> data_req_i.ce)
      else $error("data_req_o.we high while data_req_o.ce is low");

   // Load-use hold never lasts two cycles
   stall_single: assert property (@(posedge clk) disable iff (!rst_n_i)
                                  stall_i |=> !stall_i)
      else $error("stall held for more than one cycle");

   fetch_always_on: assert property (@(posedge clk) disable iff (!rst_n_i)
                                     $past(rst_n_i) |-> inst_req_i.ce)
      else $error("inst_req_o.ce dropped after reset");

endmodule

bind riscv riscv_props props_i (
   .clk, .rst_n_i, .inst_req_i(inst_req_o), .data_req_i(data_req_o), .stall_i(stall)
);

/* test/riscv_tb.sv */
`include "riscv_config.svh"

module riscv_tb;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int IMEM_WORDS = 64;
   localparam int DMEM_WORDS = 64;

   logic                      clk;
   logic                      rst_n_i;
   riscv_pipe_pkg::imem_req_t inst_req_o;
   logic [31:0]               inst_i;
   riscv_pipe_pkg::dmem_req_t data_req_o;
   logic [`RV_XLEN-1:0]       data_i;

   logic [31:0] imem [IMEM_WORDS];
   logic [31:0] dmem [DMEM_WORDS];
   logic [31:0] prog [$];       // Program table
   logic [31:0] exp_addr [$];   // Expected stores, in order
   logic [31:0] exp_data [$];
   logic [31:0] mreg [32];      // Architectural register model
   int          skip;           // Words left in a taken branch's shadow
   int          load_rd;        // Destination of the word just placed, if a load
   int          exp_stalls;
   int          n_stores;
   int          n_repeats;
   int          errors;
   int          cycles;
   int          limit;
   logic [31:0] prev_fetch;
   logic        fetched;

   riscv riscv_i (.clk, .rst_n_i, .inst_req_o, .inst_i, .data_req_o, .data_i);

   always #10 clk = ~clk;

   function automatic logic [31:0] fill_word(input logic [31:0] addr);
      return (addr * 32'h9e37_79b1) ^ 32'h5a5a_0f0f;
   endfunction

   // Places a word and tells whether the model executes it
   function automatic bit append_word(input logic [31:0] word);
      prog.push_back(word);
      load_rd = 0;
      if (skip > 0) begin
         skip--;
         return 1'b0;
      end
      return 1'b1;
   endfunction

   task automatic write_reg(input int rd, input logic [31:0] value);
      if (rd != 0) mreg[rd] = value;
   endtask

   task automatic add_imm(input int rd, input int rs1, input logic [11:0] imm);
      if (append_word({imm, 5'(rs1), 3'b000, 5'(rd), 7'b0010011}))
         write_reg(rd, mreg[rs1] + {{20{imm[11]}}, imm});   // Sign-extended immediate
   endtask

   task automatic reg_op(input riscv_isa_pkg::alu_op_e op, input int rd, input int rs1,
                         input int rs2);
      logic [2:0]  f3;
      logic [6:0]  f7;
      logic [31:0] r;
      bit          uses_load;
      uses_load = load_rd != 0 && (rs1 == load_rd || rs2 == load_rd);
      f3 = (op == riscv_isa_pkg::AND) ? 3'b111 : (op == riscv_isa_pkg::OR) ? 3'b110 : 3'b000;
      f7 = (op == riscv_isa_pkg::SUB) ? 7'b0100000 : 7'b0000000;
      case (op)
         riscv_isa_pkg::SUB: r = mreg[rs1] - mreg[rs2];   // Wraps modulo 2^32
         riscv_isa_pkg::AND: r = mreg[rs1] & mreg[rs2];
         riscv_isa_pkg::OR:  r = mreg[rs1] | mreg[rs2];
         default:            r = mreg[rs1] + mreg[rs2];
      endcase
      if (append_word({f7, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'b0110011})) begin
         write_reg(rd, r);
         exp_stalls += int'(uses_load);
      end
   endtask

   task automatic load_word(input int rd, input int rs1, input logic [11:0] off);
      if (append_word({off, 5'(rs1), 3'b010, 5'(rd), 7'b0000011})) begin
         write_reg(rd, fill_word(mreg[rs1] + {{20{off[11]}}, off}));   // Never stored before
         load_rd = rd;
      end
   endtask

   task automatic store_word(input int rs2, input int rs1, input logic [11:0] off);
      if (append_word({off[11:5], 5'(rs2), 5'(rs1), 3'b010, off[4:0], 7'b0100011})) begin
         exp_addr.push_back(mreg[rs1] + {{20{off[11]}}, off});
         exp_data.push_back(mreg[rs2]);
      end
   endtask

   // Forward offsets only
   task automatic branch_eq(input int rs1, input int rs2, input logic [12:0] off);
      if (append_word({off[12], off[10:5], 5'(rs2), 5'(rs1), 3'b000, off[4:1], off[11],
                       7'b1100011}) && mreg[rs1] == mreg[rs2])
         skip = int'(off) / 4 - 1;
   endtask

   task automatic build_program();
      foreach (mreg[i]) mreg[i] = '0;
      add_imm(1, 0, 12'($urandom));
      add_imm(2, 0, 12'($urandom) | 12'h800);   // Always negative
      reg_op(riscv_isa_pkg::ADD, 3, 1, 2);      // Distances one and two
      reg_op(riscv_isa_pkg::SUB, 4, 3, 1);      // x1 at distance three
      reg_op(riscv_isa_pkg::AND, 5, 4, 2);
      reg_op(riscv_isa_pkg::OR, 6, 5, 3);
      store_word(3, 0, 12'h040);
      store_word(4, 0, 12'h044);
      store_word(5, 0, 12'h048);
      store_word(6, 0, 12'h04c);
      add_imm(7, 6, 12'($urandom));
      store_word(7, 0, 12'h050);
      load_word(8, 0, 12'h020);
      reg_op(riscv_isa_pkg::ADD, 9, 8, 7);      // Load-use
      store_word(9, 0, 12'h054);
      branch_eq(1, 1, 13'd12);                  // Taken
      store_word(1, 0, 12'h058);
      store_word(2, 0, 12'h05c);
      store_word(6, 0, 12'h060);
      add_imm(10, 0, 12'd1);
      branch_eq(10, 0, 13'd8);                  // Not taken
      store_word(1, 0, 12'h064);
      store_word(2, 0, 12'h068);
      add_imm(0, 0, 12'($urandom));
      store_word(0, 0, 12'h06c);
   endtask

   task automatic check_store(input riscv_pipe_pkg::dmem_req_t req);
      if (n_stores >= exp_addr.size()) begin
         $display("Unexpected extra store to address %h at %0t", req.addr, $time);
         errors++;
      end else begin
         if (req.addr !== exp_addr[n_stores]) begin
            $display("ERROR at %0t: data_req_o.addr expected %h actual %h",
                     $time, exp_addr[n_stores], req.addr);
            errors++;
         end
         if (req.wdata !== exp_data[n_stores]) begin
            $display("ERROR at %0t: data_req_o.wdata expected %h actual %h",
                     $time, exp_data[n_stores], req.wdata);
            errors++;
         end
      end
      n_stores++;
   endtask

   task automatic check_idle(input riscv_pipe_pkg::dmem_req_t req);
      if (req.ce !== 1'b0) begin
         $display("ERROR at %0t: data_req_o.ce expected 0 actual %b", $time, req.ce);
         errors++;
      end
   endtask

   task automatic check_fetch(input riscv_pipe_pkg::imem_req_t req);
      if (req.ce !== 1'b1 || req.addr !== `RV_RESET_PC) begin
         $display("ERROR at %0t: inst_req_o expected %h actual %h",
                  $time, {1'b1, `RV_RESET_PC}, req);
         errors++;
      end
   endtask

   task automatic check_count(input int stores, input int repeats);
      if (stores < exp_addr.size()) begin
         $display("Missing stores: only %0d of %0d expected stores appeared",
                  stores, exp_addr.size());
         errors++;
      end
      if (repeats != exp_stalls) begin
         $display("ERROR at %0t: inst_req_o.addr repeats expected %0d actual %0d",
                  $time, exp_stalls, repeats);
         errors++;
      end
   endtask

   // Memory models driven on the falling edge
   always @(negedge clk) begin
      if (rst_n_i && data_req_o.ce && data_req_o.we) begin
         check_store(data_req_o);
         dmem[data_req_o.addr[7:2]] = data_req_o.wdata;
      end
      if (rst_n_i && inst_req_o.ce) begin
         if (fetched && inst_req_o.addr == prev_fetch)
            n_repeats++;
         prev_fetch = inst_req_o.addr;
         fetched = 1'b1;
      end
      inst_i = (inst_req_o.addr[31:2] < IMEM_WORDS) ? imem[inst_req_o.addr[7:2]] : 32'h0;
      data_i = dmem[data_req_o.addr[7:2]];
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles > limit) begin
         $display("Timeout after %0d cycles, fetch never passed the end of the program",
                  limit);
         $display("Errors: %0d", errors);
         $display("SIMULATION FAILED");
         $finish;
      end
   end

   initial begin
      clk = 1'b0;
      rst_n_i = 1'b0;
      inst_i = '0;
      data_i = '0;
      skip = 0;
      load_rd = 0;
      exp_stalls = 0;
      n_stores = 0;
      n_repeats = 0;
      errors = 0;
      cycles = 0;
      fetched = 1'b0;
      prev_fetch = '0;
      void'($urandom(57942));
      build_program();
      limit = prog.size() * 3 + 50;
      foreach (imem[i]) imem[i] = (i < prog.size()) ? prog[i] : 32'h0;
      foreach (dmem[i]) dmem[i] = fill_word(32'(i * 4));
      repeat (5) begin
         @(negedge clk);
         check_idle(data_req_o);
      end
      rst_n_i = 1'b1;
      @(negedge clk);
      check_idle(data_req_o);
      check_fetch(inst_req_o);   // First fetch after release
      // Run until fetch has moved past the last program word
      while (inst_req_o.addr < 32'(prog.size() * 4)) begin
         @(negedge clk);
      end
      repeat (8) @(negedge clk);   // Drain the pipeline
      check_count(n_stores, n_repeats);
      $display("Errors: %0d", errors);
      if (errors == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

/* verilog.f */
+incdir+include
hw/riscv_isa_pkg.sv
hw/riscv_pipe_pkg.sv
hw/riscv_fetch.sv
hw/riscv_regfile.sv
hw/riscv_decode.sv
hw/riscv_execute.sv
hw/riscv_memory.sv
hw/riscv.sv
test/riscv_props.sv
test/riscv_tb.sv
